//--- src/tiler_geom_pkg.sv
// Tiler geometry: vector types for sizes, addresses and counts, plus default array geometry
package tiler_geom_pkg;

  // Matrix dimension or iteration count
  typedef logic [15:0] dim_t;

  // Byte address or byte stride
  typedef logic [31:0] addr_t;

  // Leftover elements along one tile dimension
  typedef logic [7:0] lftovr_t;

  // Product of iteration counts
  typedef logic [31:0] count_t;

  // Default systolic array geometry
  localparam int unsigned DefArrayWidth  = 12;
  localparam int unsigned DefArrayHeight = 4;
  localparam int unsigned DefPipeRegs    = 3;
  localparam int unsigned DefBitw        = 16;

endpackage

//--- src/gemm_op_pkg.sv
// GEMM operation encodings: host op and format codes, FPU ops, FPU formats and rounding modes
package gemm_op_pkg;

  // Operation requested by the host
  typedef enum logic [2:0] {
    MATMUL = 3'd0,
    GEMM   = 3'd1,
    ADDMAX = 3'd2,
    ADDMIN = 3'd3,
    MULMAX = 3'd4,
    MULMIN = 3'd5,
    MAXMIN = 3'd6
  } gemm_op_e;

  typedef enum logic [2:0] {
    FLOAT16    = 3'd0,
    FLOAT8     = 3'd1,
    FLOAT16ALT = 3'd2,
    FLOAT8ALT  = 3'd3
  } gemm_fmt_e;

  // FPU side encodings
  typedef enum logic [4:0] {
    FPU_FMADD  = 5'd0,
    FPU_ADD    = 5'd2,
    FPU_MUL    = 5'd3,
    FPU_MINMAX = 5'd7
  } fpu_op_e;

  typedef enum logic [2:0] {
    FPU_FP16    = 3'd2,
    FPU_FP8     = 3'd3,
    FPU_FP16ALT = 3'd4,
    FPU_FP8ALT  = 3'd5
  } fpu_fmt_e;

  typedef enum logic [2:0] {
    RNE = 3'd0,
    RTZ = 3'd1
  } rnd_mode_e;

endpackage

//--- src/tile_cfg_if.sv
// Tile configuration bundle passed from one tiler pipeline stage to the next
`timescale 1ns/1ns

interface tile_cfg_if;

  tiler_geom_pkg::dim_t    m, n, k, k_off;
  tiler_geom_pkg::addr_t   x, w, z;
  logic                    loopback;
  tiler_geom_pkg::dim_t    x_rows_iter, x_cols_iter, w_rows_iter, w_cols_iter;
  tiler_geom_pkg::lftovr_t x_rows_lftovr, x_cols_lftovr, w_rows_lftovr, w_cols_lftovr;
  tiler_geom_pkg::dim_t    x_slots;
  logic [31:0]             op_sel;
  // One-cycle strobe, fields are valid from this cycle on
  logic                    load;

  modport producer (
    output m, n, k, k_off, x, w, z, loopback,
    output x_rows_iter, x_cols_iter, w_rows_iter, w_cols_iter,
    output x_rows_lftovr, x_cols_lftovr, w_rows_lftovr, w_cols_lftovr,
    output x_slots, op_sel, load
  );

  modport consumer (
    input m, n, k, k_off, x, w, z, loopback,
    input x_rows_iter, x_cols_iter, w_rows_iter, w_cols_iter,
    input x_rows_lftovr, x_cols_lftovr, w_rows_lftovr, w_cols_lftovr,
    input x_slots, op_sel, load
  );

endinterface

//--- src/seq_mult.sv
// Shift-add sequential multiplier, one bit of b per cycle
`timescale 1ns/1ns

module seq_mult #(
  parameter int unsigned AW = 16,
  parameter int unsigned BW = 16
) (
  input  logic             clk_int,
  input  logic             rst_ni,
  input  logic             clear_i,
  input  logic             start_i,
  input  logic [AW-1:0]    a_i,
  input  logic [BW-1:0]    b_i,
  output logic [AW+BW-1:0] prod_o,
  output logic             done_o
);

  localparam int unsigned PW   = AW + BW;
  localparam int unsigned CntW = (BW > 1) ? $clog2(BW) : 1;

  logic [PW-1:0]   a_sh;
  logic [PW-1:0]   acc;
  logic [BW-1:0]   b_sh;
  logic [CntW-1:0] cnt;
  logic            run_q;

  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      run_q  <= 1'b0;
      done_o <= 1'b0;
      cnt    <= '0;
    end else if (clear_i) begin
      run_q  <= 1'b0;
      done_o <= 1'b0;
      cnt    <= '0;
    end else if (start_i) begin
      run_q  <= 1'b1;
      done_o <= 1'b0;
      cnt    <= '0;
    end else if (run_q) begin
      cnt <= cnt + 1'b1;
      // Last bit of b goes in on this cycle
      if (cnt == CntW'(BW - 1)) begin
        run_q  <= 1'b0;
        done_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_int) begin
    if (start_i) begin
      a_sh <= PW'(a_i);
      b_sh <= b_i;
      acc  <= '0;
    end else if (run_q) begin
      if (b_sh[0]) begin
        acc <= acc + a_sh;
      end
      a_sh <= a_sh << 1;
      b_sh <= b_sh >> 1;
    end
  end

  assign prod_o = acc;

endmodule

//--- src/cfg_decode_stage.sv
// Request decoder: latches the host GEMM request and builds the FPU operation selection word
`timescale 1ns/1ns

module cfg_decode_stage (
  input  logic                   clk_int,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   setback_i,
  input  logic                   start_i,
  input  logic                   loopback_i,
  input  logic                   busy_i,
  input  tiler_geom_pkg::dim_t   m_size_i,
  input  tiler_geom_pkg::dim_t   n_size_i,
  input  tiler_geom_pkg::dim_t   k_size_i,
  input  tiler_geom_pkg::dim_t   k_offset_i,
  input  tiler_geom_pkg::addr_t  x_addr_i,
  input  tiler_geom_pkg::addr_t  w_addr_i,
  input  tiler_geom_pkg::addr_t  z_addr_i,
  input  gemm_op_pkg::gemm_op_e  gemm_op_i,
  input  gemm_op_pkg::gemm_fmt_e gemm_fmt_i,
  tile_cfg_if.producer           cfg_o
);

  logic                   accept;
  logic                   gemm_sel;
  gemm_op_pkg::rnd_mode_e s1_rnd;
  gemm_op_pkg::rnd_mode_e s2_rnd;
  gemm_op_pkg::fpu_op_e   s1_op;
  gemm_op_pkg::fpu_fmt_e  fmt;

  // Busy from the schedule stage only shows up two cycles after accept,
  // so our own pending load also blocks a new strobe
  assign accept = (start_i | loopback_i) & ~busy_i & ~cfg_o.load & ~clear_i & ~setback_i;

  always_comb begin
    s1_rnd   = gemm_op_pkg::RNE;
    s2_rnd   = gemm_op_pkg::RNE;
    s1_op    = gemm_op_pkg::FPU_FMADD;
    gemm_sel = 1'b1;
    case (gemm_op_i)
      gemm_op_pkg::MATMUL: gemm_sel = 1'b0;
      gemm_op_pkg::GEMM:   gemm_sel = 1'b1;
      gemm_op_pkg::ADDMAX: begin
        s1_op  = gemm_op_pkg::FPU_ADD;
        s2_rnd = gemm_op_pkg::RTZ;
      end
      gemm_op_pkg::ADDMIN: s1_op = gemm_op_pkg::FPU_ADD;
      gemm_op_pkg::MULMAX: begin
        s1_op  = gemm_op_pkg::FPU_MUL;
        s2_rnd = gemm_op_pkg::RTZ;
      end
      gemm_op_pkg::MULMIN: s1_op = gemm_op_pkg::FPU_MUL;
      default: begin
        s1_op  = gemm_op_pkg::FPU_MINMAX;
        s1_rnd = gemm_op_pkg::RTZ;
      end
    endcase
  end

  // Input and computing formats both follow the host format code
  always_comb begin
    case (gemm_fmt_i)
      gemm_op_pkg::FLOAT16:    fmt = gemm_op_pkg::FPU_FP16;
      gemm_op_pkg::FLOAT8:     fmt = gemm_op_pkg::FPU_FP8;
      gemm_op_pkg::FLOAT16ALT: fmt = gemm_op_pkg::FPU_FP16ALT;
      default:                 fmt = gemm_op_pkg::FPU_FP8ALT;
    endcase
  end

  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_o.load <= 1'b0;
    end else begin
      cfg_o.load <= accept;
    end
  end

  always_ff @(posedge clk_int) begin
    if (accept) begin
      cfg_o.m        <= m_size_i;
      cfg_o.n        <= n_size_i;
      cfg_o.k        <= k_size_i;
      cfg_o.k_off    <= k_offset_i;
      cfg_o.x        <= x_addr_i;
      cfg_o.w        <= w_addr_i;
      cfg_o.z        <= z_addr_i;
      cfg_o.loopback <= loopback_i;
      cfg_o.op_sel   <= {s1_rnd, s2_rnd, s1_op, gemm_op_pkg::FPU_MINMAX, fmt, fmt, 9'd0, gemm_sel};
    end
  end

  // Counts are produced by the next stage
  assign cfg_o.x_rows_iter   = '0;
  assign cfg_o.x_cols_iter   = '0;
  assign cfg_o.w_rows_iter   = '0;
  assign cfg_o.w_cols_iter   = '0;
  assign cfg_o.x_rows_lftovr = '0;
  assign cfg_o.x_cols_lftovr = '0;
  assign cfg_o.w_rows_lftovr = '0;
  assign cfg_o.w_cols_lftovr = '0;
  assign cfg_o.x_slots       = '0;

endmodule

//--- src/tile_count_stage.sv
// Tile counter: iteration counts, leftovers, X buffer slots and offset-adjusted W and Z addresses
`timescale 1ns/1ns

module tile_count_stage #(
  parameter int unsigned ARRAY_WIDTH  = tiler_geom_pkg::DefArrayWidth,
  parameter int unsigned ARRAY_HEIGHT = tiler_geom_pkg::DefArrayHeight,
  parameter int unsigned PIPE_REGS    = tiler_geom_pkg::DefPipeRegs,
  parameter int unsigned BITW         = tiler_geom_pkg::DefBitw
) (
  input  logic         clk_int,
  input  logic         rst_ni,
  input  logic         clear_i,
  input  logic         setback_i,
  tile_cfg_if.consumer cfg_i,
  tile_cfg_if.producer cfg_o
);

  // Depth of one W column tile
  localparam int unsigned TileK     = ARRAY_HEIGHT * (PIPE_REGS + 1);
  localparam int unsigned ElemBytes = BITW / 8;

  tiler_geom_pkg::dim_t    x_rows_full, x_cols_full, w_cols_full, w_cols_off;
  tiler_geom_pkg::lftovr_t x_rows_lft, x_cols_lft, w_rows_lft, w_cols_lft;
  tiler_geom_pkg::dim_t    x_rows_iter, x_cols_iter, w_rows_iter, w_cols_iter;
  tiler_geom_pkg::dim_t    x_slots;
  tiler_geom_pkg::addr_t   k_off_bytes;

  assign x_rows_full = tiler_geom_pkg::dim_t'(cfg_i.m / ARRAY_WIDTH);
  assign x_rows_lft  = tiler_geom_pkg::lftovr_t'(cfg_i.m % ARRAY_WIDTH);
  assign x_cols_full = tiler_geom_pkg::dim_t'(cfg_i.n / TileK);
  assign x_cols_lft  = tiler_geom_pkg::lftovr_t'(cfg_i.n % TileK);
  assign w_rows_lft  = tiler_geom_pkg::lftovr_t'(cfg_i.n % ARRAY_HEIGHT);
  assign w_cols_full = tiler_geom_pkg::dim_t'(cfg_i.k / TileK);
  assign w_cols_lft  = tiler_geom_pkg::lftovr_t'(cfg_i.k % TileK);
  // Whole W tiles that lie before the column offset
  assign w_cols_off  = tiler_geom_pkg::dim_t'(cfg_i.k_off / TileK);

  // A partial tile costs one more iteration
  assign x_rows_iter = x_rows_full + tiler_geom_pkg::dim_t'(x_rows_lft != '0);
  assign x_cols_iter = x_cols_full + tiler_geom_pkg::dim_t'(x_cols_lft != '0);

  // W rows are padded up to a multiple of the array height
  assign w_rows_iter = (w_rows_lft == '0) ? cfg_i.n :
                       cfg_i.n + tiler_geom_pkg::dim_t'(ARRAY_HEIGHT - w_rows_lft);

  // Loopback covers only the columns skipped by the first pass
  assign w_cols_iter = cfg_i.loopback ? w_cols_off :
                       w_cols_full + tiler_geom_pkg::dim_t'(w_cols_lft != '0) - w_cols_off;

  assign x_slots = tiler_geom_pkg::dim_t'(
                     (x_cols_lft + ARRAY_HEIGHT - 1) / ARRAY_HEIGHT * ARRAY_HEIGHT);

  assign k_off_bytes = tiler_geom_pkg::addr_t'(cfg_i.k_off) * ElemBytes;

  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_o.load <= 1'b0;
    end else if (clear_i | setback_i) begin
      cfg_o.load <= 1'b0;
    end else begin
      cfg_o.load <= cfg_i.load;
    end
  end

  always_ff @(posedge clk_int) begin
    if (cfg_i.load) begin
      cfg_o.m             <= cfg_i.m;
      cfg_o.n             <= cfg_i.n;
      cfg_o.k             <= cfg_i.k;
      cfg_o.k_off         <= cfg_i.k_off;
      cfg_o.x             <= cfg_i.x;
      cfg_o.w             <= cfg_i.loopback ? cfg_i.w : cfg_i.w + k_off_bytes;
      cfg_o.z             <= cfg_i.loopback ? cfg_i.z : cfg_i.z + k_off_bytes;
      cfg_o.loopback      <= cfg_i.loopback;
      cfg_o.op_sel        <= cfg_i.op_sel;
      cfg_o.x_rows_iter   <= x_rows_iter;
      cfg_o.x_cols_iter   <= x_cols_iter;
      cfg_o.w_rows_iter   <= w_rows_iter;
      cfg_o.w_cols_iter   <= w_cols_iter;
      cfg_o.x_rows_lftovr <= x_rows_lft;
      cfg_o.x_cols_lftovr <= x_cols_lft;
      cfg_o.w_rows_lftovr <= w_rows_lft;
      cfg_o.w_cols_lftovr <= w_cols_lft;
      cfg_o.x_slots       <= x_slots;
    end
  end

endmodule

//--- src/schedule_stage.sv
// Schedule stage: store, read and length totals from chained multipliers, strides and final result
`timescale 1ns/1ns

module schedule_stage #(
  parameter int unsigned ARRAY_WIDTH = tiler_geom_pkg::DefArrayWidth,
  parameter int unsigned BITW        = tiler_geom_pkg::DefBitw
) (
  input  logic                   clk_int,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   setback_i,
  tile_cfg_if.consumer           cfg_i,
  output logic                   busy_o,
  output logic                   valid_o,
  output tiler_geom_pkg::dim_t   x_rows_iter_o,
  output tiler_geom_pkg::dim_t   x_cols_iter_o,
  output tiler_geom_pkg::dim_t   w_rows_iter_o,
  output tiler_geom_pkg::dim_t   w_cols_iter_o,
  output logic [31:0]            leftovers_o,
  output tiler_geom_pkg::dim_t   tot_stores_o,
  output tiler_geom_pkg::count_t tot_x_read_o,
  output tiler_geom_pkg::count_t w_tot_len_o,
  output tiler_geom_pkg::addr_t  x_d1_stride_o,
  output tiler_geom_pkg::addr_t  w_d0_stride_o,
  output tiler_geom_pkg::count_t z_tot_len_o,
  output tiler_geom_pkg::addr_t  z_d2_stride_o,
  output tiler_geom_pkg::dim_t   x_slots_o,
  output tiler_geom_pkg::addr_t  w_addr_o,
  output tiler_geom_pkg::addr_t  z_addr_o,
  output logic [31:0]            op_sel_o
);

  localparam int unsigned ElemBytes = BITW / 8;
  // Four counts, leftovers, stores, six totals and strides, slots, two addresses, op_sel
  localparam int unsigned ResW      = 416;

  logic [31:0]            rows_by_cols;
  logic [47:0]            by_x_cols, by_w_rows;
  logic                   done1, done1_q, done2, done3;
  logic                   mult_clr, mult2_clr, start2, res_load;
  logic                   busy_q;
  tiler_geom_pkg::addr_t  w_d0_stride;
  tiler_geom_pkg::dim_t   tot_stores;
  logic [ResW-1:0]        res_d, res_q;

  assign mult_clr = clear_i | setback_i;

  // A new load retires the done flags left over from the previous run
  assign mult2_clr = mult_clr | cfg_i.load;

  seq_mult #(.AW(16), .BW(16)) u_rows_by_cols (
    .clk_int, .rst_ni, .clear_i(mult_clr), .start_i(cfg_i.load),
    .a_i(cfg_i.x_rows_iter), .b_i(cfg_i.w_cols_iter), .prod_o(rows_by_cols), .done_o(done1)
  );

  // Both second products start on the rising edge of the first done
  assign start2 = busy_q & done1 & ~done1_q;

  seq_mult #(.AW(16), .BW(32)) u_by_x_cols (
    .clk_int, .rst_ni, .clear_i(mult2_clr), .start_i(start2),
    .a_i(cfg_i.x_cols_iter), .b_i(rows_by_cols), .prod_o(by_x_cols), .done_o(done2)
  );

  seq_mult #(.AW(16), .BW(32)) u_by_w_rows (
    .clk_int, .rst_ni, .clear_i(mult2_clr), .start_i(start2),
    .a_i(cfg_i.w_rows_iter), .b_i(rows_by_cols), .prod_o(by_w_rows), .done_o(done3)
  );

  assign res_load = busy_q & done2 & done3 & ~setback_i;

  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      valid_o <= 1'b0;
      done1_q <= 1'b0;
    end else if (clear_i | setback_i) begin
      busy_q  <= 1'b0;
      valid_o <= 1'b0;
      done1_q <= 1'b0;
    end else begin
      done1_q <= done1;
      if (cfg_i.load) begin
        busy_q  <= 1'b1;
        valid_o <= 1'b0;
      end else if (res_load) begin
        busy_q  <= 1'b0;
        valid_o <= 1'b1;
      end
    end
  end

  // The load strobe covers the cycle before busy_q sets
  assign busy_o = busy_q | cfg_i.load;

  assign tot_stores  = rows_by_cols[15:0];
  assign w_d0_stride = tiler_geom_pkg::addr_t'(cfg_i.k) * ElemBytes;

  assign res_d = {
    cfg_i.x_rows_iter, cfg_i.x_cols_iter, cfg_i.w_rows_iter, cfg_i.w_cols_iter,
    cfg_i.x_rows_lftovr, cfg_i.x_cols_lftovr, cfg_i.w_rows_lftovr, cfg_i.w_cols_lftovr,
    tot_stores, by_x_cols[31:0], by_w_rows[31:0],
    tiler_geom_pkg::addr_t'(cfg_i.n) * ElemBytes,
    w_d0_stride,
    tiler_geom_pkg::count_t'(ARRAY_WIDTH) * tiler_geom_pkg::count_t'(tot_stores),
    tiler_geom_pkg::addr_t'(ARRAY_WIDTH) * w_d0_stride,
    cfg_i.x_slots, cfg_i.w, cfg_i.z, cfg_i.op_sel
  };

  // Setback keeps the last result, clear wipes it
  always_ff @(posedge clk_int or negedge rst_ni) begin
    if (!rst_ni) begin
      res_q <= '0;
    end else if (clear_i) begin
      res_q <= '0;
    end else if (res_load) begin
      res_q <= res_d;
    end
  end

  assign {x_rows_iter_o, x_cols_iter_o, w_rows_iter_o, w_cols_iter_o, leftovers_o,
          tot_stores_o, tot_x_read_o, w_tot_len_o, x_d1_stride_o, w_d0_stride_o,
          z_tot_len_o, z_d2_stride_o, x_slots_o, w_addr_o, z_addr_o, op_sel_o} = res_q;

endmodule

//--- src/gemm_tiler_top.sv
// GEMM tiler top: request decode, tile counting and schedule stages in a three-stage pipeline
`timescale 1ns/1ns

module gemm_tiler_top #(
  parameter int unsigned ARRAY_WIDTH  = tiler_geom_pkg::DefArrayWidth,
  parameter int unsigned ARRAY_HEIGHT = tiler_geom_pkg::DefArrayHeight,
  parameter int unsigned PIPE_REGS    = tiler_geom_pkg::DefPipeRegs,
  parameter int unsigned BITW         = tiler_geom_pkg::DefBitw
) (
  input  logic                   clk_int,
  input  logic                   rst_ni,
  input  logic                   clear_i,
  input  logic                   setback_i,
  input  logic                   start_i,
  input  logic                   loopback_i,
  input  tiler_geom_pkg::dim_t   m_size_i,
  input  tiler_geom_pkg::dim_t   n_size_i,
  input  tiler_geom_pkg::dim_t   k_size_i,
  input  tiler_geom_pkg::dim_t   k_offset_i,
  input  tiler_geom_pkg::addr_t  x_addr_i,
  input  tiler_geom_pkg::addr_t  w_addr_i,
  input  tiler_geom_pkg::addr_t  z_addr_i,
  input  gemm_op_pkg::gemm_op_e  gemm_op_i,
  input  gemm_op_pkg::gemm_fmt_e gemm_fmt_i,
  output logic                   busy_o,
  output logic                   valid_o,
  output tiler_geom_pkg::dim_t   x_rows_iter_o,
  output tiler_geom_pkg::dim_t   x_cols_iter_o,
  output tiler_geom_pkg::dim_t   w_rows_iter_o,
  output tiler_geom_pkg::dim_t   w_cols_iter_o,
  output logic [31:0]            leftovers_o,
  output tiler_geom_pkg::dim_t   tot_stores_o,
  output tiler_geom_pkg::count_t tot_x_read_o,
  output tiler_geom_pkg::count_t w_tot_len_o,
  output tiler_geom_pkg::addr_t  x_d1_stride_o,
  output tiler_geom_pkg::addr_t  w_d0_stride_o,
  output tiler_geom_pkg::count_t z_tot_len_o,
  output tiler_geom_pkg::addr_t  z_d2_stride_o,
  output tiler_geom_pkg::dim_t   x_slots_o,
  output tiler_geom_pkg::addr_t  w_addr_o,
  output tiler_geom_pkg::addr_t  z_addr_o,
  output logic [31:0]            op_sel_o
);

  tile_cfg_if cfg_a ();
  tile_cfg_if cfg_b ();

  cfg_decode_stage u_cfg_decode_stage (
    .clk_int, .rst_ni, .clear_i, .setback_i, .start_i, .loopback_i,
    .busy_i(busy_o),
    .m_size_i, .n_size_i, .k_size_i, .k_offset_i, .x_addr_i, .w_addr_i, .z_addr_i,
    .gemm_op_i, .gemm_fmt_i,
    .cfg_o(cfg_a.producer)
  );

  tile_count_stage #(
    .ARRAY_WIDTH(ARRAY_WIDTH), .ARRAY_HEIGHT(ARRAY_HEIGHT),
    .PIPE_REGS(PIPE_REGS), .BITW(BITW)
  ) u_tile_count_stage (
    .clk_int, .rst_ni, .clear_i, .setback_i,
    .cfg_i(cfg_a.consumer),
    .cfg_o(cfg_b.producer)
  );

  schedule_stage #(.ARRAY_WIDTH(ARRAY_WIDTH), .BITW(BITW)) u_schedule_stage (
    .clk_int, .rst_ni, .clear_i, .setback_i,
    .cfg_i(cfg_b.consumer),
    .busy_o, .valid_o,
    .x_rows_iter_o, .x_cols_iter_o, .w_rows_iter_o, .w_cols_iter_o, .leftovers_o,
    .tot_stores_o, .tot_x_read_o, .w_tot_len_o, .x_d1_stride_o, .w_d0_stride_o,
    .z_tot_len_o, .z_d2_stride_o, .x_slots_o, .w_addr_o, .z_addr_o, .op_sel_o
  );

endmodule

//--- testbench/tiler_ref_model.svh
// Tiler reference model: expected counts, leftovers and op selection from the tiling rules
`ifndef TILER_REF_MODEL_SVH
`define TILER_REF_MODEL_SVH

localparam int unsigned RefWidth  = tiler_geom_pkg::DefArrayWidth;
localparam int unsigned RefHeight = tiler_geom_pkg::DefArrayHeight;
localparam int unsigned RefTileK  = RefHeight * (tiler_geom_pkg::DefPipeRegs + 1);
localparam int unsigned RefBytes  = tiler_geom_pkg::DefBitw / 8;

function automatic int unsigned ceil_div(input int unsigned a, input int unsigned b);
  return (a + b - 1) / b;
endfunction

function automatic int unsigned x_row_tiles(input int unsigned m);
  return ceil_div(m, RefWidth);
endfunction

function automatic int unsigned x_col_tiles(input int unsigned n);
  return ceil_div(n, RefTileK);
endfunction

// N padded up to whole array rows
function automatic int unsigned w_rows_padded(input int unsigned n);
  return ceil_div(n, RefHeight) * RefHeight;
endfunction

// Loopback covers only the tiles before the column offset
function automatic int unsigned w_col_tiles(input int unsigned k, input int unsigned koff,
                                            input logic lb);
  if (lb) begin
    return koff / RefTileK;
  end
  return ceil_div(k, RefTileK) - koff / RefTileK;
endfunction

function automatic logic [31:0] pack_leftovers(input int unsigned m, input int unsigned n,
                                               input int unsigned k);
  return {8'(m % RefWidth), 8'(n % RefTileK), 8'(n % RefHeight), 8'(k % RefTileK)};
endfunction

function automatic int unsigned x_buffer_slots(input int unsigned n);
  return ceil_div(n % RefTileK, RefHeight) * RefHeight;
endfunction

function automatic logic [31:0] op_select_word(input logic [2:0] op, input logic [2:0] fmt);
  logic [31:0] word;
  logic [2:0]  fpu_fmt;
  case (fmt)
    gemm_op_pkg::FLOAT16:    fpu_fmt = gemm_op_pkg::FPU_FP16;
    gemm_op_pkg::FLOAT8:     fpu_fmt = gemm_op_pkg::FPU_FP8;
    gemm_op_pkg::FLOAT16ALT: fpu_fmt = gemm_op_pkg::FPU_FP16ALT;
    default:                 fpu_fmt = gemm_op_pkg::FPU_FP8ALT;
  endcase
  word        = '0;
  word[31:29] = gemm_op_pkg::RNE;
  word[28:26] = gemm_op_pkg::RNE;
  word[25:21] = gemm_op_pkg::FPU_FMADD;
  word[20:16] = gemm_op_pkg::FPU_MINMAX;
  word[15:13] = fpu_fmt;
  word[12:10] = fpu_fmt;
  word[0]     = (op != gemm_op_pkg::MATMUL);
  case (op)
    gemm_op_pkg::ADDMAX: begin
      word[25:21] = gemm_op_pkg::FPU_ADD;
      word[28:26] = gemm_op_pkg::RTZ;
    end
    gemm_op_pkg::ADDMIN: word[25:21] = gemm_op_pkg::FPU_ADD;
    gemm_op_pkg::MULMAX: begin
      word[25:21] = gemm_op_pkg::FPU_MUL;
      word[28:26] = gemm_op_pkg::RTZ;
    end
    gemm_op_pkg::MULMIN: word[25:21] = gemm_op_pkg::FPU_MUL;
    gemm_op_pkg::MAXMIN: begin
      word[25:21] = gemm_op_pkg::FPU_MINMAX;
      word[31:29] = gemm_op_pkg::RTZ;
    end
    default: ;
  endcase
  return word;
endfunction

`endif

//--- testbench/tb_gemm_tiler.sv
// GEMM tiler testbench: table-driven requests, setback, clear and busy checks against a model
`timescale 1ns/1ns

module tb_gemm_tiler;

  logic                   clk_int, rst_ni, clear_i, setback_i, start_i, loopback_i;
  tiler_geom_pkg::dim_t   m_size_i, n_size_i, k_size_i, k_offset_i;
  tiler_geom_pkg::addr_t  x_addr_i, w_addr_i, z_addr_i;
  gemm_op_pkg::gemm_op_e  gemm_op_i;
  gemm_op_pkg::gemm_fmt_e gemm_fmt_i;
  logic                   busy_o, valid_o;
  tiler_geom_pkg::dim_t   x_rows_iter_o, x_cols_iter_o, w_rows_iter_o, w_cols_iter_o;
  logic [31:0]            leftovers_o, op_sel_o;
  tiler_geom_pkg::dim_t   tot_stores_o, x_slots_o;
  tiler_geom_pkg::count_t tot_x_read_o, w_tot_len_o, z_tot_len_o;
  tiler_geom_pkg::addr_t  x_d1_stride_o, w_d0_stride_o, z_d2_stride_o, w_addr_o, z_addr_o;

  // Stimulus table, one entry per request
  int unsigned tab_m[$], tab_n[$], tab_k[$], tab_koff[$];
  logic [2:0]  tab_op[$], tab_fmt[$];
  logic        tab_lb[$];
  logic [31:0] tab_w[$], tab_z[$];
  string       tab_name[$];

  string test_name;
  int    mismatch_count = 0;
  int    timeout_count  = 0;
  int    seed;

  `include "tiler_ref_model.svh"

  gemm_tiler_top u_gemm_tiler_top (
    .clk_int, .rst_ni, .clear_i, .setback_i, .start_i, .loopback_i,
    .m_size_i, .n_size_i, .k_size_i, .k_offset_i, .x_addr_i, .w_addr_i, .z_addr_i,
    .gemm_op_i, .gemm_fmt_i, .busy_o, .valid_o,
    .x_rows_iter_o, .x_cols_iter_o, .w_rows_iter_o, .w_cols_iter_o, .leftovers_o,
    .tot_stores_o, .tot_x_read_o, .w_tot_len_o, .x_d1_stride_o, .w_d0_stride_o,
    .z_tot_len_o, .z_d2_stride_o, .x_slots_o, .w_addr_o, .z_addr_o, .op_sel_o
  );

  initial begin
    clk_int = 1'b0;
    forever #4 clk_int = ~clk_int;
  end

  task automatic check_value(input string field, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      mismatch_count++;
      $display("mismatch %s %s expected %h actual %h", test_name, field, expected, actual);
    end
  endtask

  task automatic add_entry(input int unsigned m, input int unsigned n, input int unsigned k,
                           input int unsigned koff, input logic [2:0] op,
                           input logic [2:0] fmt, input logic lb, input string name);
    tab_w.push_back(32'h0002_0000 + tab_m.size() * 32'h40);
    tab_z.push_back(32'h0008_0000 + tab_m.size() * 32'h80);
    tab_m.push_back(m);
    tab_n.push_back(n);
    tab_k.push_back(k);
    tab_koff.push_back(koff);
    tab_op.push_back(op);
    tab_fmt.push_back(fmt);
    tab_lb.push_back(lb);
    tab_name.push_back(name);
  endtask

  task automatic build_table();
    int unsigned rk;
    add_entry(24, 32, 48, 0, gemm_op_pkg::GEMM, gemm_op_pkg::FLOAT16, 1'b0, "exact_multiples");
    add_entry(120, 64, 160, 0, gemm_op_pkg::MATMUL, gemm_op_pkg::FLOAT8, 1'b0, "exact_large");
    add_entry(25, 37, 50, 0, gemm_op_pkg::GEMM, gemm_op_pkg::FLOAT16, 1'b0, "remainders");
    add_entry(5, 3, 7, 0, gemm_op_pkg::ADDMAX, gemm_op_pkg::FLOAT8, 1'b0, "remainder_small");
    add_entry(36, 20, 100, 40, gemm_op_pkg::GEMM, gemm_op_pkg::FLOAT16, 1'b0, "koff_shift");
    add_entry(36, 20, 100, 40, gemm_op_pkg::GEMM, gemm_op_pkg::FLOAT16, 1'b1, "loopback_raw");
    add_entry(12, 16, 64, 8, gemm_op_pkg::MULMIN, gemm_op_pkg::FLOAT8ALT, 1'b1, "loopback_zero");
    add_entry(50, 45, 300, 170, gemm_op_pkg::MAXMIN, gemm_op_pkg::FLOAT16ALT, 1'b1,
              "loopback_big");
    // Every operation with every format
    for (int o = 0; o < 7; o++) begin
      for (int f = 0; f < 4; f++) begin
        add_entry(13 + o * 7, 17 + f * 5, 33 + o + f, o * 3, 3'(o), 3'(f), 1'b0,
                  $sformatf("op%0d_fmt%0d", o, f));
      end
    end
    seed = 32'h5914;
    for (int i = 0; i < 20; i++) begin
      rk = ($unsigned($random(seed)) % 1023) + 2;
      add_entry(($unsigned($random(seed)) % 1023) + 1, ($unsigned($random(seed)) % 1023) + 1,
                rk, $unsigned($random(seed)) % rk, 3'($unsigned($random(seed)) % 7),
                3'($unsigned($random(seed)) % 4), 1'($random(seed)),
                $sformatf("random_%0d", i));
    end
  endtask

  task automatic check_outputs(input int idx);
    int unsigned m, n, k, koff, stores;
    logic        lb;
    m      = tab_m[idx];
    n      = tab_n[idx];
    k      = tab_k[idx];
    koff   = tab_koff[idx];
    lb     = tab_lb[idx];
    stores = x_row_tiles(m) * w_col_tiles(k, koff, lb);
    check_value("x_rows_iter", x_row_tiles(m), x_rows_iter_o);
    check_value("x_cols_iter", x_col_tiles(n), x_cols_iter_o);
    check_value("w_rows_iter", w_rows_padded(n), w_rows_iter_o);
    check_value("w_cols_iter", w_col_tiles(k, koff, lb), w_cols_iter_o);
    check_value("leftovers", pack_leftovers(m, n, k), leftovers_o);
    check_value("x_slots", x_buffer_slots(n), x_slots_o);
    check_value("tot_stores", stores[15:0], tot_stores_o);
    check_value("tot_x_read", stores * x_col_tiles(n), tot_x_read_o);
    check_value("w_tot_len", stores * w_rows_padded(n), w_tot_len_o);
    check_value("x_d1_stride", n * RefBytes, x_d1_stride_o);
    check_value("w_d0_stride", k * RefBytes, w_d0_stride_o);
    check_value("z_tot_len", RefWidth * stores[15:0], z_tot_len_o);
    check_value("z_d2_stride", RefWidth * k * RefBytes, z_d2_stride_o);
    check_value("w_addr", lb ? tab_w[idx] : tab_w[idx] + koff * RefBytes, w_addr_o);
    check_value("z_addr", lb ? tab_z[idx] : tab_z[idx] + koff * RefBytes, z_addr_o);
    check_value("op_sel", op_select_word(tab_op[idx], tab_fmt[idx]), op_sel_o);
  endtask

  // Drives one request, starting on a falling edge
  task automatic issue(input int idx);
    m_size_i   = tiler_geom_pkg::dim_t'(tab_m[idx]);
    n_size_i   = tiler_geom_pkg::dim_t'(tab_n[idx]);
    k_size_i   = tiler_geom_pkg::dim_t'(tab_k[idx]);
    k_offset_i = tiler_geom_pkg::dim_t'(tab_koff[idx]);
    x_addr_i   = 32'h0001_0000;
    w_addr_i   = tab_w[idx];
    z_addr_i   = tab_z[idx];
    gemm_op_i  = gemm_op_pkg::gemm_op_e'(tab_op[idx]);
    gemm_fmt_i = gemm_op_pkg::gemm_fmt_e'(tab_fmt[idx]);
    start_i    = ~tab_lb[idx];
    loopback_i = tab_lb[idx];
    @(negedge clk_int);
    start_i    = 1'b0;
    loopback_i = 1'b0;
  endtask

  task automatic clear_pipe();
    clear_i = 1'b1;
    @(negedge clk_int);
    clear_i = 1'b0;
  endtask

  task automatic wait_valid(output logic ok);
    int cycles;
    cycles = 0;
    while (valid_o !== 1'b1 && cycles < 200) begin
      @(negedge clk_int);
      cycles++;
    end
    ok = (valid_o === 1'b1);
    if (!ok) begin
      timeout_count++;
      $display("timeout: valid_o did not rise within 200 cycles in %s", test_name);
    end
  endtask

  task automatic run_and_check(input int idx);
    logic ok;
    test_name = tab_name[idx];
    clear_pipe();
    issue(idx);
    wait_valid(ok);
    if (ok) begin
      check_outputs(idx);
    end
  endtask

  initial begin
    logic ok;
    rst_ni     = 1'b0;
    clear_i    = 1'b0;
    setback_i  = 1'b0;
    start_i    = 1'b0;
    loopback_i = 1'b0;
    m_size_i   = '0;
    n_size_i   = '0;
    k_size_i   = '0;
    k_offset_i = '0;
    x_addr_i   = '0;
    w_addr_i   = '0;
    z_addr_i   = '0;
    gemm_op_i  = gemm_op_pkg::MATMUL;
    gemm_fmt_i = gemm_op_pkg::FLOAT16;
    build_table();
    repeat (2) @(negedge clk_int);
    rst_ni = 1'b1;

    for (int i = 0; i < tab_name.size(); i++) begin
      run_and_check(i);
    end

    // Setback in mid-run keeps the previous result
    run_and_check(0);
    test_name = "setback_mid_run";
    issue(2);
    repeat (10) @(negedge clk_int);
    setback_i = 1'b1;
    @(negedge clk_int);
    setback_i = 1'b0;
    for (int c = 0; c < 80; c++) begin
      check_value("valid_o", 32'd0, valid_o);
      @(negedge clk_int);
    end
    check_outputs(0);

    test_name = "clear_wipes";
    clear_pipe();
    check_value("valid_o", 32'd0, valid_o);
    check_value("tot_x_read", 32'd0, tot_x_read_o);
    check_value("w_addr", 32'd0, w_addr_o);
    check_value("op_sel", 32'd0, op_sel_o);
    check_value("any result bit", 32'd0, |{x_rows_iter_o, x_cols_iter_o, w_rows_iter_o,
      w_cols_iter_o, leftovers_o, tot_stores_o, w_tot_len_o, x_d1_stride_o, w_d0_stride_o,
      z_tot_len_o, z_d2_stride_o, x_slots_o, z_addr_o});

    // Second start lands while the first run is busy
    clear_pipe();
    test_name = "start_while_busy";
    check_value("busy_o", 32'd0, busy_o);
    issue(2);
    repeat (5) @(negedge clk_int);
    check_value("busy_o", 32'd1, busy_o);
    issue(3);
    wait_valid(ok);
    if (ok) begin
      check_value("busy_o", 32'd0, busy_o);
      check_outputs(2);
    end

    $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+testbench
src/tiler_geom_pkg.sv
src/gemm_op_pkg.sv
src/tile_cfg_if.sv
src/seq_mult.sv
src/cfg_decode_stage.sv
src/tile_count_stage.sv
src/schedule_stage.sv
src/gemm_tiler_top.sv
testbench/tb_gemm_tiler.sv

//--- Bender.yml
package:
  name: gemm_tiler

sources:
  # Packages first, then the interface and the modules bottom up
  - src/tiler_geom_pkg.sv
  - src/gemm_op_pkg.sv
  - src/tile_cfg_if.sv
  - src/seq_mult.sv
  - src/cfg_decode_stage.sv
  - src/tile_count_stage.sv
  - src/schedule_stage.sv
  - src/gemm_tiler_top.sv

  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_gemm_tiler.sv
